// ==== fp_mul_unit.f ====
source/fp_format_pkg.sv
source/axi_lite_pkg.sv
source/fp_multiplier_stage1.sv
source/fp_significand_multiplier.sv
source/fp_special_classifier.sv
source/fp_normalize_round.sv
source/fp_mul_axi_regs.sv
source/fp_mul_unit.sv
test/fp_mul_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --top-module fp_mul_unit_tb \
	-f fp_mul_unit.f -o fp_mul_unit_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/fp_mul_unit_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$log_file"; then
	exit 1
fi
exit 0

// ==== test/fp_mul_unit_tb.sv ====
`timescale 1ns/100ps

module fp_mul_unit_tb;
	import fp_format_pkg::*;
	import axi_lite_pkg::*;

	// Cycles any single handshake may take
	localparam int WAIT_LIMIT = 32;
	// Status reads before giving up on done
	localparam int DONE_POLL_LIMIT = 16;

	logic clk;
	logic reset;
	axi_write_req_t write_req;
	axi_write_rsp_t write_rsp;
	axi_read_req_t read_req;
	axi_read_rsp_t read_rsp;

	int seed;
	int error_count;
	int test_errors_start;
	int tests_passed;
	int tests_failed;
	string test_name;
	string check_label;
	logic check_strobe;
	logic [31:0] check_expected;
	logic [31:0] check_actual;

	fp_mul_unit i_fp_mul_unit
	(
		.clk(clk),
		.reset(reset),
		.write_req(write_req),
		.write_rsp(write_rsp),
		.read_req(read_req),
		.read_rsp(read_rsp)
	);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Every compare goes through this one check
	value_matches: assert property (@(posedge clk) check_strobe |-> check_actual == check_expected)
		else
		begin
			error_count++;
			$display("Mismatch in %s (%s): expected %08h, actual %08h",
				test_name, check_label, check_expected, check_actual);
		end

	// Expected product from IEEE rules, truncation, flush to zero
	function automatic logic [31:0] reference_fmul(input logic [31:0] a, input logic [31:0] b);
		logic sign;
		logic a_nan;
		logic b_nan;
		logic a_inf;
		logic b_inf;
		logic a_zero;
		logic b_zero;
		logic [47:0] significand_product;
		logic [22:0] fraction;
		int sum;
		int exponent;
		sign = a[31] ^ b[31];
		a_nan = a[30:23] == 8'hff && a[22:0] != 23'd0;
		b_nan = b[30:23] == 8'hff && b[22:0] != 23'd0;
		a_inf = a[30:23] == 8'hff && a[22:0] == 23'd0;
		b_inf = b[30:23] == 8'hff && b[22:0] == 23'd0;
		// Subnormals count as zero
		a_zero = a[30:23] == 8'h00;
		b_zero = b[30:23] == 8'h00;
		if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf))
			return CANONICAL_NAN;
		if (a_inf || b_inf)
			return {sign, 8'hff, 23'd0};
		if (a_zero || b_zero)
			return {sign, 31'd0};
		// Unbiased exponent sum must fit a signed byte
		sum = int'(a[30:23]) + int'(b[30:23]) - 2 * EXPONENT_BIAS;
		if (sum > 127)
			return {sign, 8'hff, 23'd0};
		significand_product = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
		// Product of two values in [1,2) lies in [1,4)
		exponent = sum + EXPONENT_BIAS + (significand_product[47] ? 1 : 0);
		if (exponent >= 255)
			return {sign, 8'hff, 23'd0};
		if (significand_product[47])
			fraction = significand_product[46:24];
		else
			fraction = significand_product[45:23];
		return {sign, 8'(exponent), fraction};
	endfunction

	// Expected conversion of a signed integer, truncated
	function automatic logic [31:0] reference_itof(input logic [31:0] value);
		logic [31:0] magnitude;
		logic [31:0] aligned;
		int msb;
		if (value == 32'd0)
			return 32'd0;
		magnitude = value[31] ? -value : value;
		msb = 0;
		for (int i = 0; i < 32; i++)
			if (magnitude[i])
				msb = i;
		// Leading one lands on bit 23
		if (msb >= 23)
			aligned = magnitude >> (msb - 23);
		else
			aligned = magnitude << (23 - msb);
		return {value[31], 8'(EXPONENT_BIAS + msb), aligned[22:0]};
	endfunction

	// Exponent range keeps every product clear of underflow and overflow
	function automatic logic [31:0] random_normal(input logic sign);
		logic [7:0] exponent;
		logic [22:0] significand;
		exponent = 8'(64 + {$random(seed)} % 127);
		significand = 23'($random(seed));
		return {sign, exponent, significand};
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// Holds the values over one edge so the assertion sees them
	task automatic compare_value(input string label, input logic [31:0] expected,
		input logic [31:0] actual);
		check_label = label;
		check_expected = expected;
		check_actual = actual;
		check_strobe = 1'b1;
		next_cycle();
		check_strobe = 1'b0;
	endtask

	task automatic report_timeout(input string what);
		error_count++;
		$display("Timeout in %s: no %s within the cycle limit", test_name, what);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors_start = error_count;
	endtask

	task automatic end_test();
		if (error_count == test_errors_start)
		begin
			tests_passed++;
			$display("test %s: passed", test_name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name,
				error_count - test_errors_start);
		end
	endtask

	// Address and data together, bready held low for stall_cycles
	task automatic bus_write(input logic [4:0] address, input logic [31:0] data,
		input int stall_cycles, output logic [1:0] response);
		int cycles;
		write_req.awvalid = 1'b1;
		write_req.awaddr = address;
		write_req.wvalid = 1'b1;
		write_req.wdata = data;
		write_req.wstrb = 4'hf;
		write_req.bready = stall_cycles == 0;
		cycles = 0;
		while (!(write_rsp.awready && write_rsp.wready) && cycles < WAIT_LIMIT)
		begin
			next_cycle();
			cycles++;
		end
		if (!(write_rsp.awready && write_rsp.wready))
			report_timeout("awready and wready");
		// Transfer on this edge
		next_cycle();
		write_req.awvalid = 1'b0;
		write_req.wvalid = 1'b0;
		cycles = 0;
		while (!write_rsp.bvalid && cycles < WAIT_LIMIT)
		begin
			next_cycle();
			cycles++;
		end
		if (!write_rsp.bvalid)
			report_timeout("bvalid");
		response = write_rsp.bresp;
		for (int i = 0; i < stall_cycles; i++)
			compare_value("bvalid held", 32'd1, {31'd0, write_rsp.bvalid});
		write_req.bready = 1'b1;
		next_cycle();
	endtask

	// Same shape for reads, rready held low for stall_cycles
	task automatic bus_read(input logic [4:0] address, input int stall_cycles,
		output logic [31:0] data, output logic [1:0] response);
		int cycles;
		read_req.arvalid = 1'b1;
		read_req.araddr = address;
		read_req.rready = stall_cycles == 0;
		cycles = 0;
		while (!read_rsp.arready && cycles < WAIT_LIMIT)
		begin
			next_cycle();
			cycles++;
		end
		if (!read_rsp.arready)
			report_timeout("arready");
		next_cycle();
		read_req.arvalid = 1'b0;
		cycles = 0;
		while (!read_rsp.rvalid && cycles < WAIT_LIMIT)
		begin
			next_cycle();
			cycles++;
		end
		if (!read_rsp.rvalid)
			report_timeout("rvalid");
		data = read_rsp.rdata;
		response = read_rsp.rresp;
		for (int i = 0; i < stall_cycles; i++)
			compare_value("rvalid held", 32'd1, {31'd0, read_rsp.rvalid});
		read_req.rready = 1'b1;
		next_cycle();
	endtask

	task automatic wait_for_done();
		logic [31:0] status;
		logic [1:0] response;
		int polls;
		status = '0;
		polls = 0;
		while (!status[0] && polls < DONE_POLL_LIMIT)
		begin
			bus_read(REG_STATUS, 0, status, response);
			polls++;
		end
		if (!status[0])
			report_timeout("done status");
	endtask

	// Full launch, wait and result check for one operation
	task automatic run_operation(input string label, input logic [31:0] a,
		input logic [31:0] b, input fp_operation_t operation);
		logic [1:0] response;
		logic [31:0] expected;
		logic [31:0] actual;
		if (operation == OP_ITOF)
			expected = reference_itof(b);
		else
			expected = reference_fmul(a, b);
		bus_write(REG_OPERAND_A, a, 0, response);
		bus_write(REG_OPERAND_B, b, 0, response);
		bus_write(REG_CONTROL, {31'd0, operation == OP_ITOF}, 0, response);
		wait_for_done();
		bus_read(REG_RESULT, 0, actual, response);
		compare_value(label, expected, actual);
	endtask

	initial
	begin
		logic [31:0] data;
		logic [31:0] status_early;
		logic [31:0] status_late;
		logic [31:0] operand;
		logic [1:0] response;
		logic [1:0] busy_response;
		seed = 41519;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		test_name = "reset";
		check_label = "";
		check_strobe = 1'b0;
		check_expected = '0;
		check_actual = '0;
		write_req = '0;
		write_req.bready = 1'b1;
		read_req = '0;
		read_req.rready = 1'b1;
		reset = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		next_cycle();

		// All four sign combinations
		begin_test("fmul_random");
		for (int i = 0; i < 16; i++)
			run_operation("random product", random_normal(i[0]), random_normal(i[1]), OP_FMUL);
		end_test();

		begin_test("itof");
		run_operation("one", 32'd0, 32'd1, OP_ITOF);
		run_operation("small positive", 32'd0, 32'd123456, OP_ITOF);
		run_operation("minus one", 32'd0, 32'hffffffff, OP_ITOF);
		run_operation("negative", 32'd0, -32'd1000000, OP_ITOF);
		run_operation("truncated bits", 32'd0, 32'h01234567, OP_ITOF);
		run_operation("largest positive", 32'd0, 32'h7fffffff, OP_ITOF);
		run_operation("most negative", 32'd0, 32'h80000000, OP_ITOF);
		run_operation("zero", 32'd0, 32'd0, OP_ITOF);
		end_test();

		begin_test("specials");
		run_operation("nan times two", 32'h7f800001, 32'h40000000, OP_FMUL);
		run_operation("three times nan", 32'h40400000, 32'hffc12345, OP_FMUL);
		run_operation("inf times zero", 32'h7f800000, 32'h00000000, OP_FMUL);
		run_operation("zero times minus inf", 32'h80000000, 32'hff800000, OP_FMUL);
		run_operation("inf times minus two", 32'h7f800000, 32'hc0000000, OP_FMUL);
		run_operation("minus 1.5 times zero", 32'hbfc00000, 32'h00000000, OP_FMUL);
		run_operation("subnormal flushed", 32'h00001234, 32'h40a00000, OP_FMUL);
		end_test();

		begin_test("overflow");
		run_operation("large times large", 32'h7f000000, 32'h7f000000, OP_FMUL);
		run_operation("negative large", 32'hff000000, 32'h7f000000, OP_FMUL);
		run_operation("normalize to 255", 32'h7f7fffff, 32'h3fc00000, OP_FMUL);
		run_operation("largest exponent kept", 32'h7f000000, 32'h3f800000, OP_FMUL);
		end_test();

		begin_test("protocol");
		bus_write(REG_OPERAND_A, 32'h40400000, 0, response);
		bus_write(REG_OPERAND_B, 32'h40000000, 0, response);
		bus_write(REG_CONTROL, 32'd0, 0, response);
		// Status reads fire three and five edges after the launch edge
		next_cycle();
		bus_read(REG_STATUS, 0, status_early, response);
		bus_read(REG_STATUS, 0, status_late, response);
		compare_value("busy after launch", 32'h2, status_early);
		compare_value("done within four cycles", 32'h1, status_late);
		// Second control write lands while the first is in flight
		bus_write(REG_CONTROL, 32'd0, 0, response);
		bus_write(REG_CONTROL, 32'd1, 0, busy_response);
		bus_read(REG_STATUS, 0, data, response);
		compare_value("control write while busy", 32'(RESP_SLVERR), 32'(busy_response));
		compare_value("done cleared by launch", 32'h2, data);
		wait_for_done();
		bus_read(REG_RESULT, 0, data, response);
		compare_value("busy write ignored", reference_fmul(32'h40400000, 32'h40000000), data);
		bus_write(5'h14, 32'hdeadbeef, 0, response);
		compare_value("unmapped write", 32'(RESP_SLVERR), 32'(response));
		bus_read(5'h1c, 0, data, response);
		compare_value("unmapped read response", 32'(RESP_SLVERR), 32'(response));
		compare_value("unmapped read data", 32'd0, data);
		end_test();

		begin_test("stalled_responses");
		operand = random_normal(1'b1);
		bus_write(REG_OPERAND_A, operand, 0, response);
		bus_write(REG_OPERAND_B, 32'h3fc00000, 0, response);
		bus_write(REG_CONTROL, 32'd0, 0, response);
		// Result comes back while rready is low
		bus_read(REG_STATUS, 6, data, response);
		compare_value("rvalid released", 32'd0, {31'd0, read_rsp.rvalid});
		compare_value("status during stall", 32'h2, data);
		wait_for_done();
		bus_read(REG_RESULT, 0, data, response);
		compare_value("result captured in stall", reference_fmul(operand, 32'h3fc00000), data);
		bus_write(REG_OPERAND_A, 32'd0, 4, response);
		compare_value("bvalid released", 32'd0, {31'd0, write_rsp.bvalid});
		compare_value("stalled write response", 32'(RESP_OKAY), 32'(response));
		end_test();

		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== source/fp_mul_unit.sv ====
`timescale 1ns/100ps

module fp_mul_unit
(
	input logic clk,
	input logic reset,
	input axi_lite_pkg::axi_write_req_t write_req,
	output axi_lite_pkg::axi_write_rsp_t write_rsp,
	input axi_lite_pkg::axi_read_req_t read_req,
	output axi_lite_pkg::axi_read_rsp_t read_rsp
);
	import fp_format_pkg::*;

	fp_issue_t issue;
	stage1_result_t stage1;
	product_result_t product;
	special_class_t special;
	fp_result_t result;

	fp_mul_axi_regs i_fp_mul_axi_regs
	(
		.clk(clk),
		.reset(reset),
		.write_req(write_req),
		.write_rsp(write_rsp),
		.read_req(read_req),
		.read_rsp(read_rsp),
		.issue(issue),
		.result(result)
	);

	// Exponent path and significand setup
	fp_multiplier_stage1 i_fp_multiplier_stage1
	(
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.stage1(stage1)
	);

	// Runs beside stage1 and the multiplier
	fp_special_classifier i_fp_special_classifier
	(
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.special(special)
	);

	fp_significand_multiplier i_fp_significand_multiplier
	(
		.clk(clk),
		.reset(reset),
		.stage1(stage1),
		.product(product)
	);

	fp_normalize_round i_fp_normalize_round
	(
		.clk(clk),
		.reset(reset),
		.product(product),
		.special(special),
		.result(result)
	);

endmodule

// ==== source/fp_mul_axi_regs.sv ====
`timescale 1ns/100ps

module fp_mul_axi_regs
(
	input logic clk,
	input logic reset,
	input axi_lite_pkg::axi_write_req_t write_req,
	output axi_lite_pkg::axi_write_rsp_t write_rsp,
	input axi_lite_pkg::axi_read_req_t read_req,
	output axi_lite_pkg::axi_read_rsp_t read_rsp,
	output fp_format_pkg::fp_issue_t issue,
	input fp_format_pkg::fp_result_t result
);
	import axi_lite_pkg::*;
	import fp_format_pkg::*;

	fp_operand_u operand_a;
	fp_operand_u operand_b;
	fp_operation_t operation;
	logic [31:0] result_word;
	logic launch;
	logic busy;
	logic done;
	logic bvalid;
	logic [1:0] bresp;
	logic rvalid;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic write_fire;
	logic read_fire;
	logic write_mapped;
	logic control_write;
	logic launch_accept;
	logic read_mapped;
	logic [31:0] read_data;

	// Address and data accepted in the same cycle
	assign write_fire = write_req.awvalid && write_req.wvalid && !bvalid;
	assign read_fire = read_req.arvalid && !rvalid;
	assign write_mapped = write_req.awaddr inside
		{REG_OPERAND_A, REG_OPERAND_B, REG_CONTROL, REG_STATUS, REG_RESULT};
	assign control_write = write_fire && write_req.awaddr == REG_CONTROL;
	// Launch only from idle
	assign launch_accept = control_write && !busy;

	always_comb
	begin
		read_mapped = 1'b1;
		case (read_req.araddr)
			REG_OPERAND_A: read_data = operand_a;
			REG_OPERAND_B: read_data = operand_b;
			REG_CONTROL: read_data = {31'd0, operation == OP_ITOF};
			REG_STATUS: read_data = {30'd0, busy, done};
			REG_RESULT: read_data = result_word;
			default:
			begin
				read_data = '0;
				read_mapped = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			launch <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			// One cycle issue pulse
			launch <= launch_accept;
			if (launch_accept)
			begin
				busy <= 1'b1;
				done <= 1'b0;
			end
			else if (result.valid)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (write_fire)
				bvalid <= 1'b1;
			else if (write_req.bready)
				bvalid <= 1'b0;
			if (read_fire)
				rvalid <= 1'b1;
			else if (read_req.rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (write_fire)
		begin
			for (int lane = 0; lane < 4; lane++)
				if (write_req.wstrb[lane])
				begin
					if (write_req.awaddr == REG_OPERAND_A)
						operand_a[lane*8 +: 8] <= write_req.wdata[lane*8 +: 8];
					if (write_req.awaddr == REG_OPERAND_B)
						operand_b[lane*8 +: 8] <= write_req.wdata[lane*8 +: 8];
				end
			// Busy control write or unknown offset
			if (!write_mapped || (control_write && busy))
				bresp <= RESP_SLVERR;
			else
				bresp <= RESP_OKAY;
		end
		if (launch_accept)
			operation <= write_req.wdata[0] ? OP_ITOF : OP_FMUL;
		// Captured even while a channel is stalled
		if (result.valid)
			result_word <= result.word;
		if (read_fire)
		begin
			rdata <= read_data;
			rresp <= read_mapped ? RESP_OKAY : RESP_SLVERR;
		end
	end

	assign write_rsp = '{awready: !bvalid, wready: !bvalid, bvalid: bvalid, bresp: bresp};
	assign read_rsp = '{arready: !rvalid, rvalid: rvalid, rdata: rdata, rresp: rresp};
	assign issue = '{valid: launch, operation: operation, operand_a: operand_a,
		operand_b: operand_b};

	bvalid_held: assert property (@(posedge clk) disable iff (reset)
		bvalid && !write_req.bready |=> bvalid)
		else $error("bvalid dropped before bready");

	rvalid_held: assert property (@(posedge clk) disable iff (reset)
		rvalid && !read_req.rready |=> rvalid)
		else $error("rvalid dropped before rready");

	// Pipeline output only for a launched operation
	result_only_when_busy: assert property (@(posedge clk) disable iff (reset)
		result.valid |-> busy)
		else $error("result arrived while idle");

endmodule

// ==== source/fp_normalize_round.sv ====
`timescale 1ns/100ps

module fp_normalize_round
(
	input logic clk,
	input logic reset,
	input fp_format_pkg::product_result_t product,
	input fp_format_pkg::special_class_t special,
	output fp_format_pkg::fp_result_t result
);
	import fp_format_pkg::*;

	logic [5:0] lead_position;
	logic [PRODUCT_WIDTH-1:0] shifted;
	logic [22:0] significand;
	logic signed [9:0] adjusted_exponent;
	logic [31:0] result_word;

	// Highest set bit wins
	always_comb
	begin
		lead_position = '0;
		for (int i = 0; i < PRODUCT_WIDTH; i++)
			if (product.product[i])
				lead_position = 6'(i);
	end

	// Leading one to the top, then keep the next 23 bits
	assign shifted = product.product << (6'(PRODUCT_WIDTH - 1) - lead_position);
	assign significand = shifted[PRODUCT_WIDTH-2 -: 23];

	// 1.0 times 1.0 puts the leading one at bit 46
	assign adjusted_exponent = $signed({2'b00, product.exponent})
		+ $signed({4'b0000, lead_position}) - 10'sd46;

	always_comb
	begin
		if (special.is_nan || special.inf_times_zero)
			result_word = CANONICAL_NAN;
		else if (special.is_infinity || product.overflow || adjusted_exponent >= 10'sd255)
			result_word = {product.sign, 8'hff, 23'd0};
		else if (special.is_zero)
			result_word = {product.sign, 31'd0};
		else
			result_word = {product.sign, adjusted_exponent[7:0], significand};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			result.valid <= 1'b0;
		else
		begin
			result.valid <= product.valid;
			result.word <= result_word;
		end
	end

	// Classifier and multiplier agree on which items are ordinary
	finite_product_nonzero: assert property (@(posedge clk) disable iff (reset)
		product.valid && !(special.is_nan || special.is_infinity || special.is_zero
			|| special.inf_times_zero) |-> product.product != '0)
		else $error("zero product on an operand not flagged zero");

endmodule

// ==== source/fp_special_classifier.sv ====
`timescale 1ns/100ps

module fp_special_classifier
(
	input logic clk,
	input logic reset,
	input fp_format_pkg::fp_issue_t issue,
	output fp_format_pkg::special_class_t special
);
	import fp_format_pkg::*;

	logic nan_a;
	logic nan_b;
	logic inf_a;
	logic inf_b;
	logic zero_a;
	logic zero_b;
	special_class_t decoded;
	special_class_t decoded_q;

	// All ones exponent, significand tells NaN from infinity
	assign nan_a = &issue.operand_a.fields.exponent && |issue.operand_a.fields.significand;
	assign nan_b = &issue.operand_b.fields.exponent && |issue.operand_b.fields.significand;
	assign inf_a = &issue.operand_a.fields.exponent && !(|issue.operand_a.fields.significand);
	assign inf_b = &issue.operand_b.fields.exponent && !(|issue.operand_b.fields.significand);
	// Subnormals flush to zero too
	assign zero_a = issue.operand_a.fields.exponent == 8'd0;
	assign zero_b = issue.operand_b.fields.exponent == 8'd0;

	always_comb
	begin
		decoded = '0;
		if (issue.operation == OP_ITOF)
			decoded.is_zero = issue.operand_b.int_value == 32'sd0;
		else
		begin
			decoded.is_nan = nan_a || nan_b;
			decoded.inf_times_zero = (inf_a && zero_b) || (zero_a && inf_b);
			decoded.is_infinity = inf_a || inf_b;
			decoded.is_zero = zero_a || zero_b;
		end
	end

	// Two register delay, lines up with the product
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			decoded_q <= '0;
			special <= '0;
		end
		else
		begin
			decoded_q <= decoded;
			special <= decoded_q;
		end
	end

endmodule

// ==== source/fp_significand_multiplier.sv ====
`timescale 1ns/100ps

module fp_significand_multiplier
(
	input logic clk,
	input logic reset,
	input fp_format_pkg::stage1_result_t stage1,
	output fp_format_pkg::product_result_t product
);
	import fp_format_pkg::*;

	logic [PRODUCT_WIDTH-1:0] full_product;

	// Full width product, no bits dropped here
	assign full_product = PRODUCT_WIDTH'(stage1.multiplicand) * PRODUCT_WIDTH'(stage1.multiplier);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			product.valid <= 1'b0;
		else
		begin
			product.valid <= stage1.valid;
			product.product <= full_product;
			// Exponent and sign just ride along
			product.exponent <= stage1.exponent;
			product.sign <= stage1.sign;
			product.overflow <= stage1.overflow;
		end
	end

endmodule

// ==== source/fp_multiplier_stage1.sv ====
`timescale 1ns/100ps

module fp_multiplier_stage1
(
	input logic clk,
	input logic reset,
	input fp_format_pkg::fp_issue_t issue,
	output fp_format_pkg::stage1_result_t stage1
);
	import fp_format_pkg::*;

	logic sign_a;
	logic sign_b;
	logic [7:0] exponent_a;
	logic [7:0] exponent_b;
	logic [23:0] multiplicand;
	logic [31:0] multiplier;
	logic [7:0] unbiased_a;
	logic [7:0] unbiased_b;
	logic [7:0] unbiased_sum;
	logic overflow;

	always_comb
	begin
		if (issue.operation == OP_ITOF)
		begin
			// Operand A becomes 1.0
			sign_a = 1'b0;
			exponent_a = 8'(EXPONENT_BIAS);
			multiplicand = 24'h800000;
			// Integer in operand B, unnormalized magnitude
			sign_b = issue.operand_b.int_value[31];
			exponent_b = 8'(ITOF_EXPONENT);
			if (sign_b)
				multiplier = 32'(-issue.operand_b.int_value);
			else
				multiplier = issue.operand_b.int_value;
		end
		else
		begin
			sign_a = issue.operand_a.fields.sign;
			exponent_a = issue.operand_a.fields.exponent;
			// Hidden bit only for nonzero exponent
			multiplicand = {exponent_a != 8'd0, issue.operand_a.fields.significand};
			sign_b = issue.operand_b.fields.sign;
			exponent_b = issue.operand_b.fields.exponent;
			multiplier = {8'd0, exponent_b != 8'd0, issue.operand_b.fields.significand};
		end
	end

	// Remove the bias, so the sum is plain two's complement
	assign unbiased_a = {~exponent_a[7], exponent_a[6:0]} + 8'd1;
	assign unbiased_b = {~exponent_b[7], exponent_b[6:0]} + 8'd1;
	assign unbiased_sum = unbiased_a + unbiased_b;

	// Wrap of the signed sum
	// Flushed zero operands never count, the classifier owns them
	assign overflow = unbiased_a[7] == unbiased_b[7] && unbiased_sum[7] != unbiased_a[7]
		&& exponent_a != 8'd0 && exponent_b != 8'd0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			stage1.valid <= 1'b0;
		else
		begin
			stage1.valid <= issue.valid;
			stage1.multiplicand <= multiplicand;
			stage1.multiplier <= multiplier;
			// Re-bias
			stage1.exponent <= {~unbiased_sum[7], unbiased_sum[6:0]} - 8'd1;
			stage1.sign <= sign_a ^ sign_b;
			stage1.overflow <= overflow;
		end
	end

	issue_operation_known: assert property (@(posedge clk) disable iff (reset)
		issue.valid |-> issue.operation inside {OP_FMUL, OP_ITOF})
		else $error("stage1 issue with undefined operation");

endmodule

// ==== source/axi_lite_pkg.sv ====
package axi_lite_pkg;

	localparam int ADDR_WIDTH = 5;

	// Response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Register map
	localparam logic [ADDR_WIDTH-1:0] REG_OPERAND_A = 5'h00;
	localparam logic [ADDR_WIDTH-1:0] REG_OPERAND_B = 5'h04;
	// Bit 0 selects ITOF, any write launches
	localparam logic [ADDR_WIDTH-1:0] REG_CONTROL = 5'h08;
	// Bit 0 done, bit 1 busy
	localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 5'h0c;
	localparam logic [ADDR_WIDTH-1:0] REG_RESULT = 5'h10;

	// Master to slave, write side
	typedef struct packed
	{
		logic awvalid;
		logic [ADDR_WIDTH-1:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic bready;
	} axi_write_req_t;

	typedef struct packed
	{
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
	} axi_write_rsp_t;

	typedef struct packed
	{
		logic arvalid;
		logic [ADDR_WIDTH-1:0] araddr;
		logic rready;
	} axi_read_req_t;

	typedef struct packed
	{
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axi_read_rsp_t;

endpackage

// ==== source/fp_format_pkg.sv ====
package fp_format_pkg;

	// Operations a launch can request
	typedef enum logic [1:0]
	{
		OP_FMUL = 2'd0,
		OP_ITOF = 2'd1
	} fp_operation_t;

	localparam int EXPONENT_BIAS = 127;
	// Biased exponent of an integer held in the low bits, binary point below bit 0
	localparam int ITOF_EXPONENT = 150;
	// 24-bit significand times 32-bit multiplier
	localparam int PRODUCT_WIDTH = 56;
	// Quiet NaN returned for every NaN result
	localparam logic [31:0] CANONICAL_NAN = 32'h7fc00000;

	// IEEE single precision layout
	typedef struct packed
	{
		logic sign;
		logic [7:0] exponent;
		logic [22:0] significand;
	} float_fields_t;

	// Same operand word seen as a float or as a signed integer
	typedef union packed
	{
		float_fields_t fields;
		logic signed [31:0] int_value;
	} fp_operand_u;

	typedef struct packed
	{
		logic valid;
		fp_operation_t operation;
		fp_operand_u operand_a;
		fp_operand_u operand_b;
	} fp_issue_t;

	typedef struct packed
	{
		logic valid;
		logic [23:0] multiplicand;
		logic [31:0] multiplier;
		logic [7:0] exponent;
		logic sign;
		logic overflow;
	} stage1_result_t;

	typedef struct packed
	{
		logic valid;
		logic [PRODUCT_WIDTH-1:0] product;
		logic [7:0] exponent;
		logic sign;
		logic overflow;
	} product_result_t;

	typedef struct packed
	{
		logic is_nan;
		logic is_infinity;
		logic is_zero;
		logic inf_times_zero;
	} special_class_t;

	typedef struct packed
	{
		logic valid;
		logic [31:0] word;
	} fp_result_t;

endpackage
